// ==== logic/ap_parameters.sv ====
// Neuron stage definitions
`default_nettype none

package ap_parameters;

    localparam int NN_DATA_WIDTH  = 16;                    // sample and weight width.
    localparam int NN_ARRAY_WIDTH = 8;                     // window length, kept even.
    localparam int FRAC_BITS      = 8;                     // fraction bits of a weight.
    localparam int PRODUCT_WIDTH  = 2 * NN_DATA_WIDTH;     // full signed product.
    localparam int ACC_WIDTH      = 36;                    // products, 3 bits of growth, margin.
    localparam int APB_DATA_WIDTH = 32;
    localparam int ADDR_WIDTH     = 8;                     // byte address of the bank.
    localparam int W_IDX_WIDTH    = $clog2(NN_ARRAY_WIDTH);
    localparam int SAMPLE_MAX     = 2 ** (NN_DATA_WIDTH - 1) - 1;  // upper clamp of the relu.

    typedef logic signed [NN_DATA_WIDTH-1:0]  sample_t;
    typedef logic signed [NN_DATA_WIDTH-1:0]  weight_t;
    typedef logic signed [PRODUCT_WIDTH-1:0]  product_t;
    typedef logic signed [ACC_WIDTH-1:0]      acc_t;
    typedef logic        [ADDR_WIDTH-1:0]     reg_addr_t;
    typedef logic        [APB_DATA_WIDTH-1:0] apb_data_t;

    // register map, one 32 bit word per register.
    localparam reg_addr_t ADDR_W0     = 8'h00;
    localparam reg_addr_t ADDR_BIAS   = ADDR_W0 + reg_addr_t'(4 * NN_ARRAY_WIDTH);
    localparam reg_addr_t ADDR_RESULT = ADDR_BIAS + 8'h04;  // read only.

    typedef sample_t [NN_ARRAY_WIDTH-1:0] window_t;   // element 0 is the newest first sample.
    typedef weight_t [NN_ARRAY_WIDTH-1:0] weights_t;

    typedef struct packed {
        reg_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic    valid;
        sample_t value;
    } neuron_out_t;

endpackage

`default_nettype wire

// ==== logic/sample_window.sv ====
// Sample window
`timescale 1ns/1ps
`default_nettype none

module sample_window (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,      // one beat carries two samples.
    input  wire ap_parameters::sample_t in_sample1,
    input  wire ap_parameters::sample_t in_sample2,
    output ap_parameters::window_t  window,
    output logic                    window_valid
);

    ap_parameters::window_t window_next;  // window after the current beat.

    // shift two places on a beat, hold otherwise.
    always_comb begin
        window_next = window;  // hold by default.
        if (in_valid) begin
            window_next[0] = in_sample1;  // newest pair enters at the low end.
            window_next[1] = in_sample2;
            for (int i = 2; i < ap_parameters::NN_ARRAY_WIDTH; i++) begin
                window_next[i] = window[i-2];  // older samples move two places along.
            end
        end
    end

    // registered window, cleared by reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            window <= '0;
        end else begin
            window <= window_next;
        end
    end

    // flags the cycle right after a load.
    always_ff @(posedge clk) begin
        if (rst) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= in_valid;  // in_valid one cycle late.
        end
    end

endmodule

`default_nettype wire

// ==== logic/weight_regs.sv ====
// APB weight register bank
`timescale 1ns/1ps
`default_nettype none

module weight_regs (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ap_parameters::apb_req_t    apb_req,
    input  wire ap_parameters::neuron_out_t result,   // neuron output, fills the result register.
    output ap_parameters::apb_rsp_t      apb_rsp,
    output ap_parameters::weights_t      weights,
    output ap_parameters::weight_t       bias
);

    logic                                  access;     // second phase of a transfer.
    logic                                  addr_err;   // out of map or not word aligned.
    logic                                  ro_err;     // write to the result register.
    logic                                  slv_err;
    logic                                  is_weight;
    logic                                  is_bias;
    logic                                  is_result;
    ap_parameters::reg_addr_t              w_offset;   // byte offset into the weight block.
    logic [ap_parameters::W_IDX_WIDTH-1:0] w_idx;
    ap_parameters::sample_t                result_q;   // last neuron output.
    ap_parameters::apb_data_t              rd_data;

    // widen a 16 bit register to the bus, keeping the sign.
    function automatic ap_parameters::apb_data_t sign_extend(input ap_parameters::sample_t value);
        return {{(ap_parameters::APB_DATA_WIDTH - ap_parameters::NN_DATA_WIDTH)
                 {value[ap_parameters::NN_DATA_WIDTH-1]}}, value};
    endfunction

    // address decode.
    assign access    = apb_req.psel & apb_req.penable;
    assign addr_err  = (apb_req.paddr > ap_parameters::ADDR_RESULT) || (apb_req.paddr[1:0] != 2'b00);
    assign is_weight = apb_req.paddr < ap_parameters::ADDR_BIAS;    // whole weight block.
    assign is_bias   = apb_req.paddr == ap_parameters::ADDR_BIAS;
    assign is_result = apb_req.paddr == ap_parameters::ADDR_RESULT;
    assign ro_err    = apb_req.pwrite & is_result;
    assign slv_err   = addr_err | ro_err;
    assign w_offset  = apb_req.paddr - ap_parameters::ADDR_W0;
    assign w_idx     = w_offset[ap_parameters::W_IDX_WIDTH+1:2];  // word index.

    // weight and bias writes, end of the access cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            weights <= '0;
            bias    <= '0;
        end else if (access && apb_req.pwrite && !slv_err) begin
            if (is_weight) begin
                weights[w_idx] <= apb_req.pwdata[ap_parameters::NN_DATA_WIDTH-1:0];
            end else if (is_bias) begin
                bias <= apb_req.pwdata[ap_parameters::NN_DATA_WIDTH-1:0];
            end
        end
    end

    // result register follows every valid output.
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (result.valid) begin
            result_q <= result.value;  // one cycle after result.valid.
        end
    end

    // read mux.
    always_comb begin
        rd_data = '0;
        if (is_weight) begin
            rd_data = sign_extend(weights[w_idx]);
        end else if (is_bias) begin
            rd_data = sign_extend(bias);
        end else if (is_result) begin
            rd_data = sign_extend(result_q);
        end
    end

    // zero wait response; errored reads return zero.
    always_comb begin
        apb_rsp.pready  = 1'b1;                       // never stalls.
        apb_rsp.pslverr = access & slv_err;           // only in the access cycle.
        apb_rsp.prdata  = '0;
        if (access && !apb_req.pwrite && !slv_err) begin
            apb_rsp.prdata = rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/neuron_mac.sv ====
// Pipelined multiply accumulate
`timescale 1ns/1ps
`default_nettype none

module neuron_mac (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ap_parameters::window_t  window,
    input  wire                          window_valid,
    input  wire ap_parameters::weights_t weights,   // read live, changed only when idle.
    input  wire ap_parameters::weight_t  bias,
    output ap_parameters::acc_t          acc,
    output logic                         acc_valid
);

    ap_parameters::product_t prod_q [ap_parameters::NN_ARRAY_WIDTH];  // stage one products.
    logic                    prod_valid;
    ap_parameters::acc_t     bias_aligned;  // bias in product scale.
    ap_parameters::acc_t     sum_next;

    // stage one, one signed product per window element.
    always_ff @(posedge clk) begin
        if (window_valid) begin
            for (int i = 0; i < ap_parameters::NN_ARRAY_WIDTH; i++) begin
                prod_q[i] <= $signed(window[i]) * $signed(weights[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= window_valid;
        end
    end

    // bias moves up by the weight fraction so it lines up with the products.
    assign bias_aligned = ap_parameters::acc_t'(bias) <<< ap_parameters::FRAC_BITS;

    // adder tree over the products.
    always_comb begin
        sum_next = bias_aligned;
        for (int i = 0; i < ap_parameters::NN_ARRAY_WIDTH; i++) begin
            sum_next = sum_next + ap_parameters::acc_t'(prod_q[i]);  // sign extended term.
        end
    end

    // stage two, accumulator holds between valid cycles.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= prod_valid;
            if (prod_valid) begin
                acc <= sum_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/activation_relu.sv ====
// ReLU activation
`timescale 1ns/1ps
`default_nettype none

module activation_relu (
    input  wire                      clk,
    input  wire                      rst,
    input  wire ap_parameters::acc_t acc,
    input  wire                      acc_valid,
    output ap_parameters::neuron_out_t result
);

    ap_parameters::acc_t    scaled;    // accumulator back in sample scale.
    ap_parameters::sample_t clamped;

    assign scaled = acc >>> ap_parameters::FRAC_BITS;  // arithmetic, keeps the sign.

    // negative to zero, large values saturate.
    always_comb begin
        if (scaled[ap_parameters::ACC_WIDTH-1]) begin
            clamped = '0;
        end else if (scaled > ap_parameters::acc_t'(ap_parameters::SAMPLE_MAX)) begin
            clamped = ap_parameters::sample_t'(ap_parameters::SAMPLE_MAX);
        end else begin
            clamped = scaled[ap_parameters::NN_DATA_WIDTH-1:0];  // fits, top bit is zero.
        end
    end

    // output register; value holds when no new accumulator arrives.
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid <= acc_valid;  // one pulse per input beat.
            if (acc_valid) begin
                result.value <= clamped;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/nn_neuron_top.sv ====
// Neuron stage top level
`timescale 1ns/1ps
`default_nettype none

module nn_neuron_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          in_valid,
    input  wire ap_parameters::sample_t  in_sample1,
    input  wire ap_parameters::sample_t  in_sample2,
    input  wire ap_parameters::apb_req_t apb_req,
    output ap_parameters::apb_rsp_t      apb_rsp,
    output ap_parameters::neuron_out_t   result
);

    ap_parameters::window_t  window;        // newest samples, registered.
    logic                    window_valid;
    ap_parameters::weights_t weights;       // from the register bank.
    ap_parameters::weight_t  bias;
    ap_parameters::acc_t     acc;           // mac output, product scale.
    logic                    acc_valid;

    // E+1, window load.
    sample_window u_sample_window (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_sample1   (in_sample1),
        .in_sample2   (in_sample2),
        .window       (window),
        .window_valid (window_valid)
    );

    // APB bank; takes the output back for the result register.
    weight_regs u_weight_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .result  (result),
        .apb_rsp (apb_rsp),
        .weights (weights),
        .bias    (bias)
    );

    // E+2 products, E+3 sum.
    neuron_mac u_neuron_mac (
        .clk          (clk),
        .rst          (rst),
        .window       (window),
        .window_valid (window_valid),
        .weights      (weights),
        .bias         (bias),
        .acc          (acc),
        .acc_valid    (acc_valid)
    );

    // E+4, rescale and clamp.
    activation_relu u_activation_relu (
        .clk       (clk),
        .rst       (rst),
        .acc       (acc),
        .acc_valid (acc_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== tb/nn_neuron_checker.sv ====
// Neuron stage assertions
`timescale 1ns/1ps
`default_nettype none

module nn_neuron_checker (
    input wire                             clk,
    input wire                             rst,
    input wire                             in_valid,
    input wire ap_parameters::apb_req_t    apb_req,
    input wire ap_parameters::apb_rsp_t    apb_rsp,
    input wire ap_parameters::neuron_out_t result
);

    logic access;  // second phase of an APB transfer.

    assign access = apb_req.psel & apb_req.penable;

    // window, products, sum, relu: four register stages.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        result.valid == $past(in_valid, 4))
        else $error("result.valid is not in_valid delayed by 4 cycles");

    a_pready: assert property (@(posedge clk) disable iff (rst) access |-> apb_rsp.pready)
        else $error("pready low in an access cycle");

    // error response only while a transfer completes.
    a_pslverr: assert property (@(posedge clk) disable iff (rst) !access |-> !apb_rsp.pslverr)
        else $error("pslverr high outside an access cycle");

    a_relu: assert property (@(posedge clk) disable iff (rst)
        !result.value[ap_parameters::NN_DATA_WIDTH-1])
        else $error("negative value after the relu");

endmodule

bind nn_neuron_top nn_neuron_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .result   (result)
);

`default_nettype wire

// ==== tb/nn_neuron_tb.sv ====
// Neuron stage testbench
`timescale 1ns/1ps
`default_nettype none

module nn_neuron_tb;

    localparam int STREAM_BEATS = 200;
    localparam int CLAMP_ROUNDS = 4;
    localparam int CLAMP_BEATS  = 12;
    localparam int APB_XFERS    = 100;  // bound on transfers, 3 cycles each.
    // every beat may carry one idle cycle; each stream drains for 7 cycles.
    localparam int CYCLE_LIMIT  = 2 + 3 * APB_XFERS + (2 * STREAM_BEATS + 7)
                                  + CLAMP_ROUNDS * (2 * CLAMP_BEATS + 7) + 100;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    ap_parameters::sample_t     in_sample1;
    ap_parameters::sample_t     in_sample2;
    ap_parameters::apb_req_t    apb_req;
    ap_parameters::apb_rsp_t    apb_rsp;
    ap_parameters::neuron_out_t result;

    ap_parameters::sample_t     win_model [ap_parameters::NN_ARRAY_WIDTH] = '{default: '0};
    ap_parameters::weight_t     w_model [ap_parameters::NN_ARRAY_WIDTH];
    ap_parameters::weight_t     bias_model;
    ap_parameters::sample_t     last_value = '0;  // latest expected output.
    ap_parameters::neuron_out_t exp_q [$];        // one entry per cycle.
    ap_parameters::neuron_out_t exp_out;
    ap_parameters::reg_addr_t   addr;
    int                         cycle_count;

    nn_neuron_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // register value as it appears on the 32 bit bus.
    function automatic ap_parameters::apb_data_t widen(input ap_parameters::sample_t v);
        return {{(32 - ap_parameters::NN_DATA_WIDTH){v[ap_parameters::NN_DATA_WIDTH-1]}}, v};
    endfunction

    // dot product plus bias in Q8, floor rescale, clamp to 0..32767.
    function automatic ap_parameters::sample_t neuron_model();
        longint sum;
        sum = longint'(bias_model) * (longint'(1) << ap_parameters::FRAC_BITS);
        for (int k = 0; k < ap_parameters::NN_ARRAY_WIDTH; k++) begin
            sum += longint'(win_model[k]) * longint'(w_model[k]);
        end
        sum = sum >>> ap_parameters::FRAC_BITS;
        if (sum < 0) return '0;
        if (sum > 32767) return ap_parameters::sample_t'(32767);
        return ap_parameters::sample_t'(sum);
    endfunction

    function automatic ap_parameters::weight_t large_value();
        int magnitude;
        magnitude = int'($urandom_range(32767, 16384));
        if ($urandom_range(1, 0) == 1) return ap_parameters::weight_t'(-magnitude);
        return ap_parameters::weight_t'(magnitude);
    endfunction

    task automatic check_sample(input string name, input ap_parameters::sample_t expected,
                                input ap_parameters::sample_t actual);
        if (actual !== expected) begin
            $display("Error: %0t %s expected %0d got %0d", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %0t %s expected %0b got %0b", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // prdata only matters on reads.
    task automatic check_apb(input string name, input ap_parameters::apb_rsp_t expected,
                             input ap_parameters::apb_rsp_t actual, input logic is_read);
        if (actual.pready !== expected.pready || actual.pslverr !== expected.pslverr ||
            (is_read && actual.prdata !== expected.prdata)) begin
            $display("Error: %0t %s expected prdata=%h pready=%b pslverr=%b", $time, name,
                     expected.prdata, expected.pready, expected.pslverr);
            $display("       got prdata=%h pready=%b pslverr=%b",
                     actual.prdata, actual.pready, actual.pslverr);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // setup cycle, access cycle; response sampled in the middle of the access cycle.
    task automatic apb_xfer(input ap_parameters::reg_addr_t a, input logic write,
                            input ap_parameters::apb_data_t wdata,
                            input ap_parameters::apb_data_t exp_data, input logic exp_err);
        ap_parameters::apb_req_t req;
        ap_parameters::apb_rsp_t exp_rsp;
        req.paddr       = a;
        req.psel        = 1'b1;
        req.penable     = 1'b0;
        req.pwrite      = write;
        req.pwdata      = wdata;
        exp_rsp.prdata  = exp_data;
        exp_rsp.pready  = 1'b1;
        exp_rsp.pslverr = exp_err;
        @(posedge clk);
        apb_req <= req;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        check_apb($sformatf("apb_rsp at 0x%02h", a), exp_rsp, apb_rsp, !write);
        @(posedge clk);
        apb_req <= '0;  // write lands on this edge.
    endtask

    task automatic write_bank();
        for (int k = 0; k < ap_parameters::NN_ARRAY_WIDTH; k++) begin
            apb_xfer(ap_parameters::reg_addr_t'(4 * k), 1'b1, widen(w_model[k]), '0, 1'b0);
        end
        apb_xfer(ap_parameters::ADDR_BIAS, 1'b1, widen(bias_model), '0, 1'b0);
    endtask

    task automatic read_bank();
        for (int k = 0; k < ap_parameters::NN_ARRAY_WIDTH; k++) begin
            apb_xfer(ap_parameters::reg_addr_t'(4 * k), 1'b0, '0, widen(w_model[k]), 1'b0);
        end
        apb_xfer(ap_parameters::ADDR_BIAS, 1'b0, '0, widen(bias_model), 1'b0);
    endtask

    // random beats, half of them after an idle cycle, then a drain.
    task automatic send_stream(input int beats);
        for (int b = 0; b < beats; b++) begin
            @(posedge clk);
            if ($urandom_range(1, 0) == 1) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_valid   <= 1'b1;
            in_sample1 <= ap_parameters::sample_t'($urandom);
            in_sample2 <= ap_parameters::sample_t'($urandom);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (6) @(posedge clk);  // last result and result register settle.
    endtask

    // reference model. the entry of a beat is compared four falling edges after it was queued.
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_q.size() == 4) begin
                exp_out = exp_q.pop_front();
                check_flag("result.valid", exp_out.valid, result.valid);
                if (exp_out.valid) begin
                    check_sample("result.value", exp_out.value, result.value);
                    last_value = exp_out.value;
                end
            end
            exp_out.valid = in_valid;
            exp_out.value = '0;
            if (in_valid) begin
                for (int i = ap_parameters::NN_ARRAY_WIDTH - 1; i >= 2; i--) begin
                    win_model[i] = win_model[i-2];  // two places along per beat.
                end
                win_model[0]  = in_sample1;
                win_model[1]  = in_sample2;
                exp_out.value = neuron_model();
            end
            exp_q.push_back(exp_out);
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h1539_3b69));
        rst        <= 1'b1;
        in_valid   <= 1'b0;
        in_sample1 <= '0;
        in_sample2 <= '0;
        apb_req    <= '0;
        bias_model = '0;
        for (int k = 0; k < ap_parameters::NN_ARRAY_WIDTH; k++) begin
            w_model[k] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        read_bank();  // everything zero after reset.
        apb_xfer(ap_parameters::ADDR_RESULT, 1'b0, '0, '0, 1'b0);

        // moderate weights, about -1.0 to +1.0 in Q8.
        for (int k = 0; k < ap_parameters::NN_ARRAY_WIDTH; k++) begin
            w_model[k] = ap_parameters::weight_t'(int'($urandom_range(511, 0)) - 256);
        end
        bias_model = ap_parameters::weight_t'(int'($urandom_range(8191, 0)) - 4096);
        write_bank();
        read_bank();

        // out of map, misaligned, read only; none of them may touch the bank.
        addr = ap_parameters::reg_addr_t'($urandom_range(255, ap_parameters::ADDR_RESULT + 1));
        apb_xfer(addr, 1'b0, '0, '0, 1'b1);
        apb_xfer(addr, 1'b1, $urandom, '0, 1'b1);
        addr = ap_parameters::reg_addr_t'(4 * $urandom_range(8, 0) + $urandom_range(3, 1));
        apb_xfer(addr, 1'b0, '0, '0, 1'b1);
        apb_xfer(addr, 1'b1, $urandom, '0, 1'b1);
        apb_xfer(ap_parameters::ADDR_RESULT, 1'b1, $urandom, '0, 1'b1);
        read_bank();
        apb_xfer(ap_parameters::ADDR_RESULT, 1'b0, '0, widen(last_value), 1'b0);

        send_stream(STREAM_BEATS);
        apb_xfer(ap_parameters::ADDR_RESULT, 1'b0, '0, widen(last_value), 1'b0);

        // large weights push most sums past either clamp.
        for (int r = 0; r < CLAMP_ROUNDS; r++) begin
            for (int k = 0; k < ap_parameters::NN_ARRAY_WIDTH; k++) begin
                w_model[k] = large_value();
            end
            bias_model = large_value();
            write_bank();
            send_stream(CLAMP_BEATS);
            apb_xfer(ap_parameters::ADDR_RESULT, 1'b0, '0, widen(last_value), 1'b0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/ap_parameters.sv
logic/sample_window.sv
logic/weight_regs.sv
logic/neuron_mac.sv
logic/activation_relu.sv
logic/nn_neuron_top.sv
tb/nn_neuron_checker.sv
tb/nn_neuron_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the neuron stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module nn_neuron_tb -o nn_neuron_sim

# an assertion or a fatal check stops the simulator, so the log decides the outcome.
./obj_dir/nn_neuron_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
    echo "simulation did not pass"
    exit 1
fi
echo "simulation ok"
